// File: include/lawn_cfg.svh
`ifndef LAWN_CFG_SVH
`define LAWN_CFG_SVH

// Lane count and coordinate width shared by every block
`define LANE_COUNT 5
`define COORD_BITS 10

// Zombies enter at the right edge and the game is lost at this column
`define ZOMBIE_START_X 799
`define END_OF_LAWN 124

// Stagger thresholds that release the later lanes
`define ENTRY_NEAR 700
`define ENTRY_FAR 600

// Pea launch column and pixels moved per movement tick
`define PEA_START_X 160
`define PEA_STEP 4
`define HITS_TO_KILL 5

// Clock cycles per movement tick, kept short for simulation
// Any value of 2 or more keeps tick a single-cycle pulse
`define TICK_CYCLES 4

// Screen geometry in pixels
`define LAWN_TOP 160
`define ROW_HEIGHT 128
`define HEAD_SIZE 20
`define BODY_HALF_WIDTH 8
`define CURSOR_WIDTH 8
`define GRID_CELL 160

// Twelve-bit RGB colours, four bits per channel
`define BLACK 12'h000
`define GREY 12'h0B4
`define DARK_GREEN 12'h392
`define GREEN 12'h0F0
`define RED 12'hF00
`define ZOMBIE_SKIN 12'hAAB
`define ZOMBIE_HEAD 12'h6A5

`endif

// File: hw/lawnPkg.sv
`include "lawn_cfg.svh"

package lawnPkg;

	// A pixel coordinate on either axis
	typedef logic [`COORD_BITS-1:0] coordT;

	// A twelve-bit colour as driven to the VGA DAC
	typedef logic [11:0] rgbT;

	// Lane number, wide enough for all five lanes
	typedef logic [2:0] laneIdxT;

	// One wave only, so the game needs just four states
	typedef enum logic [1:0]
	{
		gameIdle = 2'd0,
		gamePlaying = 2'd1,
		gameWon = 2'd2,
		gameLost = 2'd3
	} gameStateT;

	// Everything the renderer and the game rules need to know about one lane
	// The zombie column sits in the top bits, the pea column in the bottom bits
	typedef struct packed
	{
		coordT zombieX;
		// Peas absorbed so far by this lane's zombie
		logic [3:0] hits;
		logic alive;
		// Only one pea per lane can be in flight
		logic peaActive;
		coordT peaX;
	} laneStatusT;

	// All five lanes side by side, lane 0 in the lowest slice
	typedef laneStatusT [`LANE_COUNT-1:0] laneStatusArrT;

endpackage

// File: hw/waveControl.sv
`include "lawn_cfg.svh"

module waveControl (
	input logic clk,
	input logic reset,
	input logic playing,
	input lawnPkg::laneStatusArrT laneStatus,
	output logic tick,
	output logic [`LANE_COUNT-1:0] laneEnable
);

	localparam int TickBits = $clog2(`TICK_CYCLES);

	logic [TickBits-1:0] tickCount;

	// The divider only runs while the game is being played
	// Outside play it sits at zero so the first tick is a full period away
	always_ff @(posedge clk)
	begin
		if (reset || !playing)
		begin
			tickCount <= '0;
			tick <= 1'b0;
		end
		else if (tickCount == TickBits'(`TICK_CYCLES - 1))
		begin
			tickCount <= '0;
			tick <= 1'b1;
		end
		else
		begin
			tickCount <= tickCount + 1'b1;
			tick <= 1'b0;
		end
	end

	// Lane 1 always walks in first
	assign laneEnable[1] = 1'b1;

	// Lane 0 waits until lane 1 is well onto the lawn
	assign laneEnable[0] = laneStatus[1].zombieX <= `COORD_BITS'(`ENTRY_FAR);

	// Lanes 2 and 3 both key off lane 0, lane 3 a little earlier
	assign laneEnable[2] = laneStatus[0].zombieX <= `COORD_BITS'(`ENTRY_FAR);
	assign laneEnable[3] = laneStatus[0].zombieX <= `COORD_BITS'(`ENTRY_NEAR);

	// Lane 4 follows lane 3
	assign laneEnable[4] = laneStatus[3].zombieX <= `COORD_BITS'(`ENTRY_NEAR);

	// Every lane relies on tick being a single pulse per period
	assert property (@(posedge clk) disable iff (reset) tick |=> !tick)
		else $error("tick high on two consecutive cycles");

endmodule

// File: hw/zombieLane.sv
`include "lawn_cfg.svh"

module zombieLane (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic enable,
	input logic fire,
	output lawnPkg::laneStatusT status,
	output logic killPulse
);

	import lawnPkg::*;

	coordT nextPeaX;
	logic contact;
	logic lastHit;

	// Contact is judged on the positions from before this tick's move
	assign contact = status.peaActive && status.alive && (status.peaX >= status.zombieX);

	assign nextPeaX = status.peaX + coordT'(`PEA_STEP);

	// True when the pea about to land is the killing one
	assign lastHit = status.hits == 4'(`HITS_TO_KILL - 1);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			status.zombieX <= coordT'(`ZOMBIE_START_X);
			status.hits <= 4'd0;
			status.alive <= 1'b1;
			status.peaActive <= 1'b0;
			status.peaX <= '0;
			killPulse <= 1'b0;
		end
		else
		begin
			killPulse <= 1'b0;

			// The zombie keeps walking until the lane releases it and until it dies
			if (tick && status.alive && enable)
			begin
				status.zombieX <= status.zombieX - coordT'(1);
			end

			// A landed pea is consumed instead of moving on
			if (tick && contact)
			begin
				status.peaActive <= 1'b0;
				status.hits <= status.hits + 4'd1;
				if (lastHit)
				begin
					status.alive <= 1'b0;
					killPulse <= 1'b1;
				end
			end
			else if (tick && status.peaActive)
			begin
				// A pea that gets to the right edge has missed and is dropped
				status.peaX <= nextPeaX;
				status.peaActive <= nextPeaX < coordT'(`ZOMBIE_START_X);
			end
			else if (fire && !status.peaActive)
			begin
				// Launch from the shooter column; a second fire in flight is ignored
				status.peaActive <= 1'b1;
				status.peaX <= coordT'(`PEA_START_X);
			end
		end
	end

	// The kill logic must stop counting at the limit
	assert property (@(posedge clk) disable iff (reset) status.hits <= 4'(`HITS_TO_KILL))
		else $error("hit count above the kill limit");

	// Once dead a zombie stays where it fell, tick or not
	assert property (@(posedge clk) disable iff (reset) !status.alive |=> $stable(status.zombieX))
		else $error("dead zombie moved");

endmodule

// File: hw/laneCursor.sv
`include "lawn_cfg.svh"

module laneCursor (
	input logic clk,
	input logic reset,
	input logic upPulse,
	input logic downPulse,
	input logic selectPulse,
	input logic playing,
	output lawnPkg::laneIdxT cursorLane,
	output logic [`LANE_COUNT-1:0] fireStrobe
);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cursorLane <= 3'd0;
			fireStrobe <= '0;
		end
		else
		begin
			// Up moves toward lane 0 at the top of the lawn, down toward the last lane
			// Both buttons together cancel out
			if (upPulse && !downPulse && cursorLane != 3'd0)
			begin
				cursorLane <= cursorLane - 3'd1;
			end
			else if (downPulse && !upPulse && cursorLane != 3'(`LANE_COUNT - 1))
			begin
				cursorLane <= cursorLane + 3'd1;
			end

			// Select only fires once the game runs, at the lane under the cursor
			// before any move in this same cycle
			if (selectPulse && playing)
			begin
				fireStrobe <= `LANE_COUNT'(1) << cursorLane;
			end
			else
			begin
				fireStrobe <= '0;
			end
		end
	end

	// The renderer and the fire decode both assume a legal lane number
	assert property (@(posedge clk) disable iff (reset) cursorLane < 3'(`LANE_COUNT))
		else $error("cursor outside the lawn");

endmodule

// File: hw/gameFsm.sv
`include "lawn_cfg.svh"

module gameFsm (
	input logic clk,
	input logic reset,
	input logic selectPulse,
	input lawnPkg::laneStatusArrT laneStatus,
	input logic [`LANE_COUNT-1:0] killPulse,
	output lawnPkg::gameStateT gameState,
	output logic playing,
	output logic [15:0] zombiesKilled
);

	import lawnPkg::*;

	logic [`LANE_COUNT-1:0] atEnd;
	logic anyAlive;

	// A lane breaks through when its living zombie stands on the last column
	always_comb
	begin
		anyAlive = 1'b0;
		for (int i = 0; i < `LANE_COUNT; i++)
		begin
			atEnd[i] = laneStatus[i].alive &&
				(laneStatus[i].zombieX == coordT'(`END_OF_LAWN));
			anyAlive = anyAlive || laneStatus[i].alive;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			gameState <= gameIdle;
		end
		else
		begin
			case (gameState)
				gameIdle:
				begin
					if (selectPulse)
						gameState <= gamePlaying;
				end
				gamePlaying:
				begin
					// Losing wins over winning if both show up together
					if (|atEnd)
						gameState <= gameLost;
					else if (zombiesKilled == 16'(`LANE_COUNT))
						gameState <= gameWon;
				end
				// Both end states hold until the next reset
				default:
				begin
					gameState <= gameState;
				end
			endcase
		end
	end

	// Several lanes can die on the same tick, so add them all up
	always_ff @(posedge clk)
	begin
		if (reset)
			zombiesKilled <= 16'd0;
		else
			zombiesKilled <= zombiesKilled + 16'($countones(killPulse));
	end

	assign playing = gameState == gamePlaying;

	// A won game has no zombie left standing in any lane
	assert property (@(posedge clk) disable iff (reset) gameState == gameWon |-> !anyAlive)
		else $error("game won with a zombie still alive");

	// Each lane can be killed at most once per game
	assert property (@(posedge clk) disable iff (reset) zombiesKilled <= 16'(`LANE_COUNT))
		else $error("more kills than zombies");

endmodule

// File: hw/pixelRenderer.sv
`include "lawn_cfg.svh"

module pixelRenderer (
	input logic clk,
	input logic reset,
	input logic bright,
	input lawnPkg::coordT hCount,
	input lawnPkg::coordT vCount,
	input lawnPkg::laneStatusArrT laneStatus,
	input lawnPkg::laneIdxT cursorLane,
	output lawnPkg::rgbT rgb
);

	import lawnPkg::*;

	logic inLawn;
	logic rowValid;
	coordT vLawn;
	coordT rowOffset;
	laneIdxT rowIdx;
	logic [2:0] colIdx;
	laneStatusT rowStatus;
	logic zombieHere;
	logic headCol;
	logic bodyCol;
	logic isCursor;
	logic isHead;
	logic isBody;
	logic isGrid;
	rgbT nextRgb;

	// Everything above the lawn is the grey top zone
	assign inLawn = vCount >= coordT'(`LAWN_TOP);
	assign vLawn = inLawn ? vCount - coordT'(`LAWN_TOP) : '0;

	// Row number and the line inside that row
	assign rowIdx = 3'(vLawn / `ROW_HEIGHT);
	assign rowOffset = coordT'(vLawn % `ROW_HEIGHT);
	assign rowValid = inLawn && (rowIdx < 3'(`LANE_COUNT));

	// Column of the lawn grid, used only for the checkerboard
	assign colIdx = 3'(hCount / `GRID_CELL);

	// Lines below the last lane fall back to lane 0, but rowValid masks them
	assign rowStatus = laneStatus[rowValid ? rowIdx : 3'd0];
	assign zombieHere = rowValid && rowStatus.alive;

	// Head spans HEAD_SIZE columns centred on the zombie, computed without wraparound
	assign headCol = (32'(hCount) + `HEAD_SIZE / 2 >= 32'(rowStatus.zombieX)) &&
		(32'(hCount) < 32'(rowStatus.zombieX) + `HEAD_SIZE / 2);

	// Body is a narrower strip under the head
	assign bodyCol = (32'(hCount) + `BODY_HALF_WIDTH >= 32'(rowStatus.zombieX)) &&
		(32'(hCount) <= 32'(rowStatus.zombieX) + `BODY_HALF_WIDTH);

	assign isCursor = rowValid && (rowIdx == cursorLane) && (hCount < coordT'(`CURSOR_WIDTH));
	assign isHead = zombieHere && (rowOffset < coordT'(`HEAD_SIZE)) && headCol;
	assign isBody = zombieHere && (rowOffset >= coordT'(`HEAD_SIZE)) && bodyCol;

	// Dark squares where row and column are both even
	assign isGrid = !rowIdx[0] && !colIdx[0];

	// Priority follows the draw order, blanking first and plain lawn last
	always_comb
	begin
		if (!bright)
			nextRgb = `BLACK;
		else if (isCursor)
			nextRgb = `RED;
		else if (isHead)
			nextRgb = `ZOMBIE_HEAD;
		else if (isBody)
			nextRgb = `ZOMBIE_SKIN;
		else if (!inLawn)
			nextRgb = `GREY;
		else if (isGrid)
			nextRgb = `DARK_GREEN;
		else
			nextRgb = `GREEN;
	end

	// One pipeline stage between the counters and the DAC
	always_ff @(posedge clk)
	begin
		if (reset)
			rgb <= `BLACK;
		else
			rgb <= nextRgb;
	end

endmodule

// File: hw/lawnDefenseTop.sv
`include "lawn_cfg.svh"

module lawnDefenseTop (
	input logic clk,
	input logic reset,
	input logic bright,
	input lawnPkg::coordT hCount,
	input lawnPkg::coordT vCount,
	input logic upButton,
	input logic downButton,
	input logic selectButton,
	output lawnPkg::rgbT rgb,
	output lawnPkg::gameStateT gameState,
	output logic [15:0] zombiesKilled,
	output lawnPkg::laneStatusArrT laneStatus
);

	import lawnPkg::*;

	logic tick;
	logic playing;
	logic [`LANE_COUNT-1:0] laneEnable;
	logic [`LANE_COUNT-1:0] fireStrobe;
	logic [`LANE_COUNT-1:0] killPulse;
	laneIdxT cursorLane;

	// Shared tick and the staggered entry order
	waveControl wave (
		.clk(clk),
		.reset(reset),
		.playing(playing),
		.laneStatus(laneStatus),
		.tick(tick),
		.laneEnable(laneEnable)
	);

	// One lane per row, each with its own zombie and pea
	for (genvar i = 0; i < `LANE_COUNT; i++)
	begin : lanes
		zombieLane lane (
			.clk(clk),
			.reset(reset),
			.tick(tick),
			.enable(laneEnable[i]),
			.fire(fireStrobe[i]),
			.status(laneStatus[i]),
			.killPulse(killPulse[i])
		);
	end

	// Buttons arrive already reduced to single-cycle pulses
	laneCursor cursor (
		.clk(clk),
		.reset(reset),
		.upPulse(upButton),
		.downPulse(downButton),
		.selectPulse(selectButton),
		.playing(playing),
		.cursorLane(cursorLane),
		.fireStrobe(fireStrobe)
	);

	gameFsm game (
		.clk(clk),
		.reset(reset),
		.selectPulse(selectButton),
		.laneStatus(laneStatus),
		.killPulse(killPulse),
		.gameState(gameState),
		.playing(playing),
		.zombiesKilled(zombiesKilled)
	);

	pixelRenderer renderer (
		.clk(clk),
		.reset(reset),
		.bright(bright),
		.hCount(hCount),
		.vCount(vCount),
		.laneStatus(laneStatus),
		.cursorLane(cursorLane),
		.rgb(rgb)
	);

endmodule

// File: sim/lawnTbPkg.sv
`include "lawn_cfg.svh"

package lawnTbPkg;

	import lawnPkg::*;

	// Inputs applied to the DUT for one clock cycle
	typedef struct packed
	{
		logic up;
		logic down;
		logic sel;
		logic bright;
		coordT hCount;
		coordT vCount;
	} stimT;

	// Everything the reference model keeps from one cycle to the next
	typedef struct packed
	{
		laneStatusArrT lanes;
		logic [`LANE_COUNT-1:0] kill;
		logic [`LANE_COUNT-1:0] fire;
		laneIdxT cursor;
		gameStateT state;
		logic [15:0] killed;
		logic [7:0] divider;
		logic tick;
		rgbT rgb;
	} modelT;

	// Fresh game with every zombie waiting at the entry column
	function automatic modelT resetModel();
		modelT m;
		m = '0;
		for (int i = 0; i < `LANE_COUNT; i++)
		begin
			m.lanes[i].zombieX = coordT'(`ZOMBIE_START_X);
			m.lanes[i].alive = 1'b1;
		end
		m.state = gameIdle;
		m.rgb = `BLACK;
		return m;
	endfunction

	// Colour the screen should show for one pixel, highest priority first
	function automatic rgbT pixelColour(modelT m, logic bright, coordT hCount, coordT vCount);
		int h;
		int v;
		int row;
		int offset;
		int zx;
		logic inLawn;
		logic rowOk;
		logic live;
		h = int'(hCount);
		v = int'(vCount);
		inLawn = v >= `LAWN_TOP;
		row = inLawn ? (v - `LAWN_TOP) / `ROW_HEIGHT : 0;
		offset = inLawn ? (v - `LAWN_TOP) % `ROW_HEIGHT : 0;
		rowOk = inLawn && row < `LANE_COUNT;
		zx = rowOk ? int'(m.lanes[row].zombieX) : 0;
		live = rowOk && m.lanes[row].alive;
		if (!bright)
			return `BLACK;
		if (rowOk && row == int'(m.cursor) && h < `CURSOR_WIDTH)
			return `RED;
		// Head is a square straddling the zombie column
		if (live && offset < `HEAD_SIZE && h >= zx - `HEAD_SIZE / 2 && h < zx + `HEAD_SIZE / 2)
			return `ZOMBIE_HEAD;
		if (live && offset >= `HEAD_SIZE && h >= zx - `BODY_HALF_WIDTH &&
			h <= zx + `BODY_HALF_WIDTH)
			return `ZOMBIE_SKIN;
		if (!inLawn)
			return `GREY;
		// Checkerboard of grid cells, dark where row and column are both even
		if (row % 2 == 0 && (h / `GRID_CELL) % 2 == 0)
			return `DARK_GREEN;
		return `GREEN;
	endfunction

	// One lane over one clock edge
	function automatic laneStatusT stepLane(laneStatusT l, logic tick, logic enable,
		logic fire, output logic killed);
		laneStatusT n;
		logic hit;
		n = l;
		killed = 1'b0;
		// Contact is judged before either the pea or the zombie moves
		hit = l.peaActive && l.alive && l.peaX >= l.zombieX;
		if (tick && l.alive && enable)
			n.zombieX = l.zombieX - coordT'(1);
		if (tick && hit)
		begin
			n.peaActive = 1'b0;
			n.hits = l.hits + 4'd1;
			if (n.hits == 4'(`HITS_TO_KILL))
			begin
				n.alive = 1'b0;
				killed = 1'b1;
			end
		end
		else if (tick && l.peaActive)
		begin
			n.peaX = l.peaX + coordT'(`PEA_STEP);
			// A pea that runs off the right edge is gone
			if (n.peaX >= coordT'(`ZOMBIE_START_X))
				n.peaActive = 1'b0;
		end
		else if (fire && !l.peaActive)
		begin
			n.peaActive = 1'b1;
			n.peaX = coordT'(`PEA_START_X);
		end
		return n;
	endfunction

	// Whole game over one clock edge, given the inputs sampled at that edge
	function automatic modelT stepModel(modelT m, stimT s);
		modelT n;
		logic playing;
		logic [`LANE_COUNT-1:0] enable;
		logic killed;
		logic breakthrough;
		int count;
		n = m;
		playing = m.state == gamePlaying;
		// Movement tick divider only counts while playing
		count = int'(m.divider) + 1;
		n.tick = playing && count == `TICK_CYCLES;
		n.divider = (playing && !n.tick) ? 8'(count) : 8'd0;
		// Staggered entry, lane 1 leads
		enable[1] = 1'b1;
		enable[0] = m.lanes[1].zombieX <= coordT'(`ENTRY_FAR);
		enable[2] = m.lanes[0].zombieX <= coordT'(`ENTRY_FAR);
		enable[3] = m.lanes[0].zombieX <= coordT'(`ENTRY_NEAR);
		enable[4] = m.lanes[3].zombieX <= coordT'(`ENTRY_NEAR);
		breakthrough = 1'b0;
		for (int i = 0; i < `LANE_COUNT; i++)
		begin
			if (m.lanes[i].alive && m.lanes[i].zombieX == coordT'(`END_OF_LAWN))
				breakthrough = 1'b1;
			n.lanes[i] = stepLane(m.lanes[i], m.tick, enable[i], m.fire[i], killed);
			n.kill[i] = killed;
		end
		// Fire aims at the cursor lane as it was before this edge's move
		n.fire = (s.sel && playing) ? `LANE_COUNT'(1) << m.cursor : '0;
		if (s.up && !s.down && m.cursor != 3'd0)
			n.cursor = m.cursor - 3'd1;
		else if (s.down && !s.up && int'(m.cursor) < `LANE_COUNT - 1)
			n.cursor = m.cursor + 3'd1;
		case (m.state)
			gameIdle:
			begin
				if (s.sel)
					n.state = gamePlaying;
			end
			gamePlaying:
			begin
				if (breakthrough)
					n.state = gameLost;
				else if (m.killed == 16'(`LANE_COUNT))
					n.state = gameWon;
			end
			default:
			begin
				n.state = m.state;
			end
		endcase
		n.killed = m.killed + 16'($countones(m.kill));
		n.rgb = pixelColour(m, s.bright, s.hCount, s.vCount);
		return n;
	endfunction

endpackage

// File: sim/lawnDefenseTb.sv
`include "lawn_cfg.svh"

module lawnDefenseTb;

	import lawnPkg::*;
	import lawnTbPkg::*;

	// How the button and pixel inputs are chosen each cycle
	typedef enum logic [2:0]
	{
		modeQuiet,
		modeRandom,
		modeDense,
		modeAimed,
		modePixels
	} stimModeT;

	localparam int ClockPeriod = 8;
	localparam int ResetCycles = 6;
	localparam int IdleCycles = 40;
	localparam int StaggerCycles = 1800;
	localparam int RandomCycles = 800;
	localparam int DenseCycles = 4000;
	localparam int WinCycles = 5000;
	localparam int LoseCycles = 3000;
	localparam int HoldCycles = 40;
	localparam int PixelCycles = 1500;
	localparam int TotalCycles = 6 * ResetCycles + IdleCycles + StaggerCycles + RandomCycles +
		DenseCycles + WinCycles + LoseCycles + 2 * HoldCycles + 2 + PixelCycles;
	// Ten percent of slack on top of the summed scenario budgets
	localparam int WatchdogTime = TotalCycles * ClockPeriod * 11 / 10;

	logic clk;
	logic reset;
	logic bright;
	coordT hCount;
	coordT vCount;
	logic upButton;
	logic downButton;
	logic selectButton;
	rgbT rgb;
	gameStateT gameState;
	logic [15:0] zombiesKilled;
	laneStatusArrT laneStatus;

	modelT model;
	stimT applied;
	stimModeT mode;
	logic startPending;
	string testName;
	int repeatFires;
	int markerPixels;
	int zombiePixels;
	int spent;
	laneStatusArrT frozen;

	lawnDefenseTop UUT (.*);

	always #(ClockPeriod / 2) clk = ~clk;

	task automatic stopRun();
		$display("Errors found");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic reportFailure(input string reason);
		$display("%s: %s", testName, reason);
		stopRun();
	endtask

	task automatic checkLane(input int lane, input laneStatusT expected, input laneStatusT actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: lane %0d status expected %h actual %h",
				testName, lane, expected, actual);
			stopRun();
		end
	endtask

	task automatic checkState(input gameStateT expected, input gameStateT actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: game state expected %s actual %s",
				testName, expected.name(), actual.name());
			stopRun();
		end
	endtask

	task automatic checkKilled(input logic [15:0] expected, input logic [15:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: zombies killed expected %0d actual %0d",
				testName, expected, actual);
			stopRun();
		end
	endtask

	task automatic checkRgb(input rgbT expected, input rgbT actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: pixel colour expected %h actual %h", testName, expected, actual);
			stopRun();
		end
	endtask

	task automatic compareAll();
		for (int i = 0; i < `LANE_COUNT; i++)
			checkLane(i, model.lanes[i], laneStatus[i]);
		checkState(model.state, gameState);
		checkKilled(model.killed, zombiesKilled);
		checkRgb(model.rgb, rgb);
	endtask

	// First living lane that has walked in and has no pea on the way
	function automatic int aimTarget();
		for (int i = 0; i < `LANE_COUNT; i++)
		begin
			if (model.lanes[i].alive && !model.lanes[i].peaActive && !model.fire[i] &&
				model.lanes[i].zombieX < coordT'(`ZOMBIE_START_X))
				return i;
		end
		return -1;
	endfunction

	function automatic stimT pickStimulus();
		stimT s;
		int target;
		int lane;
		int pick;
		s = '0;
		s.bright = ($urandom % 10) != 0;
		s.hCount = coordT'($urandom);
		s.vCount = coordT'($urandom);
		case (mode)
			modeRandom:
			begin
				s.up = ($urandom % 5) == 0;
				s.down = ($urandom % 5) == 0;
				s.sel = ($urandom % 7) == 0;
			end
			modeDense:
			begin
				s.up = ($urandom % 6) == 0;
				s.down = ($urandom % 6) == 0;
				s.sel = ($urandom % 2) == 0;
			end
			modeAimed:
			begin
				target = aimTarget();
				if (target >= 0)
				begin
					// Up walks toward lane 0, down toward the last lane
					if (int'(model.cursor) > target)
						s.up = 1'b1;
					else if (int'(model.cursor) < target)
						s.down = 1'b1;
					else
						s.sel = 1'b1;
				end
			end
			modePixels:
			begin
				s.up = ($urandom % 10) == 0;
				s.down = ($urandom % 10) == 0;
				s.sel = ($urandom % 20) == 0;
				lane = int'($urandom % `LANE_COUNT);
				pick = int'($urandom % 4);
				// Most pixels land in a lane row near the marker or near a zombie
				if (pick != 0)
					s.vCount = coordT'(`LAWN_TOP + lane * `ROW_HEIGHT +
						int'($urandom % `ROW_HEIGHT));
				if (pick == 1)
					s.hCount = coordT'(int'($urandom % 16));
				else if (pick >= 2)
					s.hCount = coordT'(int'(model.lanes[lane].zombieX) - 12 +
						int'($urandom % 25));
			end
			default:
			begin
				s.up = 1'b0;
			end
		endcase
		return s;
	endfunction

	// One clock edge: advance the model, drive the next inputs, compare mid-cycle
	task automatic runCycle();
		stimT next;
		@(posedge clk);
		model = stepModel(model, applied);
		for (int i = 0; i < `LANE_COUNT; i++)
		begin
			if (model.fire[i] && model.lanes[i].peaActive)
				repeatFires++;
		end
		if (model.rgb == `RED)
			markerPixels++;
		if (model.rgb == `ZOMBIE_HEAD)
			zombiePixels++;
		next = pickStimulus();
		if (startPending)
		begin
			next.sel = 1'b1;
			startPending = 1'b0;
		end
		upButton <= next.up;
		downButton <= next.down;
		selectButton <= next.sel;
		bright <= next.bright;
		hCount <= next.hCount;
		vCount <= next.vCount;
		applied = next;
		@(negedge clk);
		compareAll();
	endtask

	task automatic runCycles(input int count);
		repeat (count) runCycle();
	endtask

	task automatic applyReset();
		@(posedge clk);
		reset <= 1'b1;
		upButton <= 1'b0;
		downButton <= 1'b0;
		selectButton <= 1'b0;
		bright <= 1'b0;
		hCount <= '0;
		vCount <= '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		model = resetModel();
		applied = '0;
		startPending = 1'b0;
		@(negedge clk);
		compareAll();
	endtask

	initial
	begin
		#(WatchdogTime);
		$display("simulation timed out during %s", testName);
		stopRun();
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		bright = 1'b0;
		hCount = '0;
		vCount = '0;
		upButton = 1'b0;
		downButton = 1'b0;
		selectButton = 1'b0;
		testName = "reset";
		mode = modeQuiet;
		repeatFires = 0;
		void'($urandom(33145));

		// Nothing walks until select starts the game
		testName = "idle hold";
		applyReset();
		runCycles(IdleCycles);
		checkState(gameIdle, gameState);
		testName = "stagger";
		startPending = 1'b1;
		runCycles(StaggerCycles);
		if (laneStatus[4].zombieX == coordT'(`ZOMBIE_START_X))
			reportFailure("the last lane never entered the lawn");

		testName = "cursor and fire";
		applyReset();
		startPending = 1'b1;
		mode = modeRandom;
		repeatFires = 0;
		runCycles(RandomCycles);
		if (repeatFires == 0)
			reportFailure("no fire was ever sent at a lane with a pea in flight");

		testName = "hits and kills";
		applyReset();
		startPending = 1'b1;
		mode = modeDense;
		spent = 0;
		while (zombiesKilled < 16'd2 && gameState != gameLost && spent < DenseCycles)
		begin
			runCycle();
			spent++;
		end
		if (zombiesKilled < 16'd2)
			reportFailure("dense firing killed fewer than two zombies");

		testName = "win";
		applyReset();
		startPending = 1'b1;
		mode = modeAimed;
		spent = 0;
		while (gameState inside {gameIdle, gamePlaying} && spent < WinCycles)
		begin
			runCycle();
			spent++;
		end
		if (gameState != gameWon)
			reportFailure("aimed firing did not win the game");
		mode = modeQuiet;
		runCycles(HoldCycles);
		checkState(gameWon, gameState);

		testName = "lose";
		applyReset();
		startPending = 1'b1;
		mode = modeQuiet;
		spent = 0;
		while (gameState != gameLost && spent < LoseCycles)
		begin
			runCycle();
			spent++;
		end
		if (gameState != gameLost)
			reportFailure("no zombie reached the end of the lawn");
		// A tick already in the pipe may still land after the loss
		runCycles(2);
		frozen = laneStatus;
		runCycles(HoldCycles);
		for (int i = 0; i < `LANE_COUNT; i++)
			checkLane(i, frozen[i], laneStatus[i]);

		testName = "pixels";
		applyReset();
		startPending = 1'b1;
		mode = modePixels;
		markerPixels = 0;
		zombiePixels = 0;
		runCycles(PixelCycles);
		if (markerPixels == 0 || zombiePixels == 0)
			reportFailure("the cursor marker or a zombie head was never drawn");

		$display("No errors");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+include
hw/lawnPkg.sv
hw/waveControl.sv
hw/zombieLane.sv
hw/laneCursor.sv
hw/gameFsm.sv
hw/pixelRenderer.sv
hw/lawnDefenseTop.sv
sim/lawnTbPkg.sv
sim/lawnDefenseTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the lawn defence testbench with Verilator and runs it
# The exit status is the simulator's own, nonzero on any failure

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	-f vlog.f \
	--top-module lawnDefenseTb \
	-o simLawn
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "Verilator build failed with status $buildStatus"
	exit $buildStatus
fi

./obj_dir/simLawn
simStatus=$?
if [ $simStatus -ne 0 ]; then
	echo "Simulation failed with status $simStatus"
	exit $simStatus
fi

exit 0
